/* include/motor_defs.svh */
`ifndef MOTOR_DEFS_SVH
`define MOTOR_DEFS_SVH

// step index and step length widths
`define MOTOR_STEP_W 4
`define MOTOR_CYCLES_W 16

// a 12-bit period gives at most 4095 cycles per PWM period
`define PWM_LEN_W 12

// pulse budgets, remainders and high-cycle tallies
`define PWM_POS_W 16

// shortest on-time the MOSFET drivers switch cleanly
`define PWM_MIN_PULSE 256

// steps on which a phase defers to its neighbour phase
`define PWM_GATE_STEP_A 1
`define PWM_GATE_STEP_B 6
`define PWM_GATE_STEP_C 11

`endif

/* hw/motorPkg.sv */
package motorPkg;

`include "motor_defs.svh"

    // index of a commutation step
    typedef logic [`MOTOR_STEP_W-1:0] stepIdxT;

    // length of a step in clock cycles
    typedef logic [`MOTOR_CYCLES_W-1:0] stepCyclesT;

    // one step command from the host, 80 bits
    typedef struct packed {
        stepIdxT                 stepIdx;
        stepCyclesT              stepCycles;
        // one period shared by all three phases
        logic [`PWM_LEN_W-1:0]   pwmLen;
        logic [`PWM_POS_W-1:0]   pulseLenA;
        logic [`PWM_POS_W-1:0]   pulseLenB;
        logic [`PWM_POS_W-1:0]   pulseLenC;
    } stepCmdT;

    // step frame broadcast by the sequencer to every generator
    typedef struct packed {
        logic    active;
        // first cycle of the step, also the first period start
        logic    stepFirst;
        // final cycle of the step
        logic    stepLast;
        stepIdxT stepIdx;
    } stepFrameT;

endpackage

/* hw/pwmPkg.sv */
package pwmPkg;

`include "motor_defs.svh"

    // length of one PWM period in cycles
    typedef logic [`PWM_LEN_W-1:0] pwmLenT;

    // pulse budget, pulse counter value or high-cycle count
    typedef logic [`PWM_POS_W-1:0] pulseLenT;

    // per-step report of the cycles each phase owed but did not drive
    typedef struct packed {
        logic [`MOTOR_STEP_W-1:0] stepIdx;
        pulseLenT                 lostA;
        pulseLenT                 lostB;
        pulseLenT                 lostC;
    } pwmStatusT;

    // a phase's budget and what it would load, kept together for the
    // load or carry decision
    typedef struct packed {
        pulseLenT budget;
        logic     reachMin;
        logic     gateOk;
    } phaseBudgetT;

endpackage

/* hw/stepSequencer.sv */
`timescale 1ns/100ps

module stepSequencer (
    input  logic                clk,
    input  logic                arstN,
    input  logic                cmdValid,
    output logic                cmdReady,
    input  motorPkg::stepCmdT   cmd,
    output motorPkg::stepFrameT frame,
    output pwmPkg::pwmLenT      pwmLen,
    output pwmPkg::pulseLenT    pulseLenA,
    output pwmPkg::pulseLenT    pulseLenB,
    output pwmPkg::pulseLenT    pulseLenC
);

    typedef enum logic {
        stIdle,
        stRun
    } seqStateT;

    seqStateT             state;
    seqStateT             stateNext;
    motorPkg::stepCyclesT cycLeft;
    motorPkg::stepCmdT    cmdQ;
    logic                 accept;
    logic                 stepFirst;
    logic                 stepLast;

    // the counter starts at the full step length, so the first cycle is
    // the one where nothing has been counted off yet
    assign stepFirst = (state == stRun) && (cycLeft == cmdQ.stepCycles);
    assign stepLast  = (state == stRun) && (cycLeft == motorPkg::stepCyclesT'(1));

    // taking a command in the last cycle chains the next step without a gap
    assign cmdReady = (state == stIdle) || stepLast;
    assign accept   = cmdValid && cmdReady;

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (accept) begin
                    stateNext = stRun;
                end
            end
            stRun: begin
                if (stepLast && !accept) begin
                    stateNext = stIdle;
                end
            end
            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= stIdle;
            cycLeft <= '0;
        end else begin
            state <= stateNext;
            if (accept) begin
                cycLeft <= cmd.stepCycles;
            end else if (cycLeft != '0) begin
                cycLeft <= cycLeft - motorPkg::stepCyclesT'(1);
            end
        end
    end

    // command fields stay put for the whole step
    always_ff @(posedge clk) begin
        if (accept) begin
            cmdQ <= cmd;
        end
    end

    assign frame = '{
        active:    (state == stRun),
        stepFirst: stepFirst,
        stepLast:  stepLast,
        stepIdx:   cmdQ.stepIdx
    };

    assign pwmLen    = cmdQ.pwmLen;
    assign pulseLenA = cmdQ.pulseLenA;
    assign pulseLenB = cmdQ.pulseLenB;
    assign pulseLenC = cmdQ.pulseLenC;

endmodule

/* hw/pwmGenerator.sv */
`timescale 1ns/100ps

`include "motor_defs.svh"

module pwmGenerator #(
    parameter motorPkg::stepIdxT gateStep = '0
) (
    input  logic                clk,
    input  logic                arstN,
    input  motorPkg::stepFrameT frame,
    input  pwmPkg::pwmLenT      pwmLen,
    input  pwmPkg::pulseLenT    pulseLen,
    input  pwmPkg::pulseLenT    neighbourBudget,
    output pwmPkg::pulseLenT    budget,
    output logic                pwm,
    output pwmPkg::pulseLenT    lost,
    output logic                lostValid
);

    pwmPkg::pwmLenT      perCnt;
    logic                periodStart;
    pwmPkg::pulseLenT    remainder;
    pwmPkg::pulseLenT    remEff;
    pwmPkg::phaseBudgetT phase;
    logic                load;
    pwmPkg::pulseLenT    pulseCnt;
    pwmPkg::pulseLenT    wantedCnt;
    pwmPkg::pulseLenT    realCnt;
    pwmPkg::pulseLenT    wantedNext;
    pwmPkg::pulseLenT    realNext;

    // the step's first cycle opens a period, then every pwmLen cycles
    assign periodStart = frame.active && (frame.stepFirst || perCnt == pwmPkg::pwmLenT'(1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            perCnt <= '0;
        end else if (!frame.active) begin
            perCnt <= '0;
        end else if (periodStart) begin
            perCnt <= pwmLen;
        end else if (perCnt != '0) begin
            perCnt <= perCnt - pwmPkg::pwmLenT'(1);
        end
    end

    // a new step starts from an empty remainder
    assign remEff = frame.stepFirst ? '0 : remainder;

    assign phase.budget   = remEff + pulseLen;
    assign phase.reachMin = (phase.budget >= pwmPkg::pulseLenT'(`PWM_MIN_PULSE));
    // on its gate step this phase may not outgrow its neighbour
    assign phase.gateOk   = !((frame.stepIdx == gateStep) && (phase.budget > neighbourBudget));

    assign load   = periodStart && phase.reachMin && phase.gateOk;
    assign budget = phase.budget;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            remainder <= '0;
        end else if (periodStart) begin
            remainder <= load ? '0 : phase.budget;
        end
    end

    // the step end wins over a load in the same cycle, so nothing
    // spills past the step
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pulseCnt <= '0;
        end else if (!frame.active || frame.stepLast) begin
            pulseCnt <= '0;
        end else if (load) begin
            pulseCnt <= phase.budget;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - pwmPkg::pulseLenT'(1);
        end
    end

    assign pwm = (pulseCnt != '0);

    // tallies restart on the first cycle and include this cycle's share
    always_comb begin
        wantedNext = frame.stepFirst ? '0 : wantedCnt;
        realNext   = frame.stepFirst ? '0 : realCnt;
        if (periodStart) begin
            wantedNext = wantedNext + pulseLen;
        end
        if (pwm) begin
            realNext = realNext + pwmPkg::pulseLenT'(1);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wantedCnt <= '0;
            realCnt   <= '0;
            lostValid <= 1'b0;
        end else begin
            if (frame.active) begin
                wantedCnt <= wantedNext;
                realCnt   <= realNext;
            end
            lostValid <= frame.active && frame.stepLast;
        end
    end

    // the difference wraps at 16 bits when more was driven than wanted
    always_ff @(posedge clk) begin
        if (frame.active && frame.stepLast) begin
            lost <= wantedNext - realNext;
        end
    end

endmodule

/* hw/motorDrive.sv */
`timescale 1ns/100ps

`include "motor_defs.svh"

module motorDrive (
    input  logic              clk,
    input  logic              arstN,
    input  logic              cmdValid,
    output logic              cmdReady,
    input  motorPkg::stepCmdT cmd,
    output logic [2:0]        pwm,
    output logic              statusValid,
    output pwmPkg::pwmStatusT status
);

    motorPkg::stepFrameT frame;
    pwmPkg::pwmLenT      pwmLen;
    pwmPkg::pulseLenT    pulseLenA;
    pwmPkg::pulseLenT    pulseLenB;
    pwmPkg::pulseLenT    pulseLenC;
    pwmPkg::pulseLenT    budgetA;
    pwmPkg::pulseLenT    budgetB;
    pwmPkg::pulseLenT    budgetC;
    pwmPkg::pulseLenT    lostA;
    pwmPkg::pulseLenT    lostB;
    pwmPkg::pulseLenT    lostC;
    motorPkg::stepIdxT   statusIdx;

    stepSequencer i_stepSequencer (
        .clk       (clk),
        .arstN     (arstN),
        .cmdValid  (cmdValid),
        .cmdReady  (cmdReady),
        .cmd       (cmd),
        .frame     (frame),
        .pwmLen    (pwmLen),
        .pulseLenA (pulseLenA),
        .pulseLenB (pulseLenB),
        .pulseLenC (pulseLenC)
    );

    // budgets form a ring: A looks at B, B at C, C at A
    pwmGenerator #(
        .gateStep (motorPkg::stepIdxT'(`PWM_GATE_STEP_A))
    ) i_pwmGenA (
        .clk             (clk),
        .arstN           (arstN),
        .frame           (frame),
        .pwmLen          (pwmLen),
        .pulseLen        (pulseLenA),
        .neighbourBudget (budgetB),
        .budget          (budgetA),
        .pwm             (pwm[0]),
        .lost            (lostA),
        .lostValid       (statusValid)
    );

    pwmGenerator #(
        .gateStep (motorPkg::stepIdxT'(`PWM_GATE_STEP_B))
    ) i_pwmGenB (
        .clk             (clk),
        .arstN           (arstN),
        .frame           (frame),
        .pwmLen          (pwmLen),
        .pulseLen        (pulseLenB),
        .neighbourBudget (budgetC),
        .budget          (budgetB),
        .pwm             (pwm[1]),
        .lost            (lostB),
        .lostValid       ()
    );

    pwmGenerator #(
        .gateStep (motorPkg::stepIdxT'(`PWM_GATE_STEP_C))
    ) i_pwmGenC (
        .clk             (clk),
        .arstN           (arstN),
        .frame           (frame),
        .pwmLen          (pwmLen),
        .pulseLen        (pulseLenC),
        .neighbourBudget (budgetA),
        .budget          (budgetC),
        .pwm             (pwm[2]),
        .lost            (lostC),
        .lostValid       ()
    );

    // the frame may already carry the next step when the status goes out
    always_ff @(posedge clk) begin
        if (frame.active && frame.stepLast) begin
            statusIdx <= frame.stepIdx;
        end
    end

    assign status = '{
        stepIdx: statusIdx,
        lostA:   lostA,
        lostB:   lostB,
        lostC:   lostC
    };

endmodule

/* verification/motorDriveTb.sv */
`timescale 1ns/100ps

module motorDriveTb;

    localparam int NUM_STEPS = 7;
    localparam int MAX_GAP   = 8;

    typedef struct packed {
        motorPkg::stepCmdT cmd;
        logic              gap;
        pwmPkg::pulseLenT  highA;
        pwmPkg::pulseLenT  highB;
        pwmPkg::pulseLenT  highC;
        pwmPkg::pulseLenT  lostA;
        pwmPkg::pulseLenT  lostB;
        pwmPkg::pulseLenT  lostC;
    } stepEntryT;

    logic              clk;
    logic              arstN;
    logic              cmdValid;
    logic              cmdReady;
    motorPkg::stepCmdT cmd;
    logic [2:0]        pwm;
    logic              statusValid;
    pwmPkg::pwmStatusT status;

    stepEntryT        steps [NUM_STEPS];
    int               acceptCycle [NUM_STEPS];
    pwmPkg::pulseLenT highCnt [3];
    int               cycleCnt;
    int               cycleLimit;
    int               statusCnt;
    logic [31:0]      rngState;

    motorDrive i_motorDrive (
        .clk         (clk),
        .arstN       (arstN),
        .cmdValid    (cmdValid),
        .cmdReady    (cmdReady),
        .cmd         (cmd),
        .pwm         (pwm),
        .statusValid (statusValid),
        .status      (status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic stepEntryT makeEntry(input int idx, input int cycles, input int len,
                                            input int lenA, input int lenB, input int lenC,
                                            input bit gap,
                                            input int hA, input int hB, input int hC,
                                            input int lA, input int lB, input int lC);
        stepEntryT e;
        e.cmd.stepIdx    = motorPkg::stepIdxT'(idx);
        e.cmd.stepCycles = motorPkg::stepCyclesT'(cycles);
        e.cmd.pwmLen     = pwmPkg::pwmLenT'(len);
        e.cmd.pulseLenA  = pwmPkg::pulseLenT'(lenA);
        e.cmd.pulseLenB  = pwmPkg::pulseLenT'(lenB);
        e.cmd.pulseLenC  = pwmPkg::pulseLenT'(lenC);
        e.gap            = gap;
        e.highA          = pwmPkg::pulseLenT'(hA);
        e.highB          = pwmPkg::pulseLenT'(hB);
        e.highC          = pwmPkg::pulseLenT'(hC);
        e.lostA          = pwmPkg::pulseLenT'(lA);
        e.lostB          = pwmPkg::pulseLenT'(lB);
        e.lostC          = pwmPkg::pulseLenT'(lC);
        return e;
    endfunction

    // period starts fall on cycles 0, P, 2P and so on; a pulse loaded at
    // cycle c is high from c+1 and is cut after the last cycle N-1
    task automatic fillTable();
        // plain pulses, the last one of each phase truncated to 199 cycles
        steps[0] = makeEntry(2, 1000, 400, 300, 256, 400, 1, 799, 711, 999, 101, 57, 201);
        // A carries 100 and 200 and fires 300 at cycle 600, then carries again
        steps[1] = makeEntry(3, 1000, 300, 100, 256, 300, 0, 300, 867, 999, 100, 157, 201);
        // step 6 gates B against C's budget of 300, so B never fires
        steps[2] = makeEntry(6, 900, 400, 300, 350, 300, 1, 699, 0, 699, 201, 1050, 201);
        steps[3] = makeEntry(7, 900, 400, 300, 350, 300, 0, 699, 799, 699, 201, 251, 201);
        steps[4] = makeEntry(9, 500, 300, 256, 280, 0, 1, 455, 479, 0, 57, 81, 0);
        // shortest step, one high cycle per phase
        steps[5] = makeEntry(10, 2, 300, 260, 256, 300, 0, 1, 1, 1, 259, 255, 299);
        // step 1 gates A, but 280 does not exceed B's 300
        steps[6] = makeEntry(1, 600, 300, 280, 300, 256, 1, 560, 599, 512, 0, 1, 0);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %s: got %h, expected %h", name, got, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // one cycle, sampled mid-cycle where all outputs are settled
    task automatic tick();
        stepEntryT entry;
        @(negedge clk);
        cycleCnt++;
        if (cycleCnt > cycleLimit) begin
            $display("timeout after %0d cycles with %0d statuses seen", cycleCnt, statusCnt);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
        if (statusValid) begin
            if (statusCnt >= NUM_STEPS) begin
                $display("status pulse seen after the last step had reported");
                $display(">>> FAIL");
                $fatal(1, "unexpected status");
            end
            entry = steps[statusCnt];
            checkValue("status.stepIdx", status.stepIdx, entry.cmd.stepIdx);
            checkValue("status.lostA", status.lostA, entry.lostA);
            checkValue("status.lostB", status.lostB, entry.lostB);
            checkValue("status.lostC", status.lostC, entry.lostC);
            checkValue("pwm[0] high cycles", highCnt[0], entry.highA);
            checkValue("pwm[1] high cycles", highCnt[1], entry.highB);
            checkValue("pwm[2] high cycles", highCnt[2], entry.highC);
            for (int p = 0; p < 3; p++) begin
                highCnt[p] = '0;
            end
            statusCnt++;
        end
        for (int p = 0; p < 3; p++) begin
            if (pwm[p]) begin
                highCnt[p] = highCnt[p] + 1'b1;
            end
        end
    endtask

    initial begin
        int sumCycles;
        int gapLen;
        arstN     = 1'b0;
        cmdValid  = 1'b0;
        cmd       = '0;
        cycleCnt  = 0;
        statusCnt = 0;
        rngState  = 32'h3783424d;
        for (int p = 0; p < 3; p++) begin
            highCnt[p] = '0;
        end
        fillTable();
        sumCycles = 0;
        for (int i = 0; i < NUM_STEPS; i++) begin
            sumCycles += int'(steps[i].cmd.stepCycles);
        end
        cycleLimit = 2 * (sumCycles + MAX_GAP * NUM_STEPS) + 100;

        repeat (4) tick();
        arstN = 1'b1;
        tick();
        checkValue("cmdReady", cmdReady, 1);
        checkValue("pwm", pwm, 0);
        checkValue("statusValid", statusValid, 0);

        for (int i = 0; i < NUM_STEPS; i++) begin
            if (steps[i].gap) begin
                // let the drive fall idle, then hold the command back a while
                while (statusCnt < i) begin
                    tick();
                end
                rngState = nextRandom(rngState);
                gapLen   = 1 + int'(rngState % MAX_GAP);
                repeat (gapLen) begin
                    tick();
                    checkValue("pwm", pwm, 0);
                    checkValue("statusValid", statusValid, 0);
                end
            end
            cmdValid = 1'b1;
            cmd      = steps[i].cmd;
            while (!cmdReady) begin
                tick();
            end
            // cmdReady was high here, so the next rising edge takes the command
            tick();
            acceptCycle[i] = cycleCnt;
            if (i > 0 && !steps[i].gap) begin
                // a chained command is taken in the last cycle of the step before it
                checkValue("cmdReady accept distance", acceptCycle[i] - acceptCycle[i-1],
                           steps[i-1].cmd.stepCycles);
            end
            cmdValid = 1'b0;
            cmd      = '0;
        end

        while (statusCnt < NUM_STEPS) begin
            tick();
        end
        repeat (10) begin
            tick();
            checkValue("pwm", pwm, 0);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

/* project.f */
+incdir+include
hw/motorPkg.sv
hw/pwmPkg.sv
hw/stepSequencer.sv
hw/pwmGenerator.sv
hw/motorDrive.sv
verification/motorDriveTb.sv

/* Bender.yml */
package:
  name: motor_drive

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/motorPkg.sv
      - hw/pwmPkg.sv
      - hw/stepSequencer.sv
      - hw/pwmGenerator.sv
      - hw/motorDrive.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/motorDriveTb.sv
